// File: common/osd_pkg.sv
// --------------------
// osd overlay shared defs
// --------------------
package osd_pkg;

  typedef logic [23:0] pix_t;         // rgb888 pixel
  typedef logic [11:0] coord_t;       // raster x or y
  typedef logic [7:0]  cmd_t;         // command byte
  typedef logic [7:0]  glyph_row_t;   // bit n drawn at column n
  typedef logic [2:0]  digit_t;       // digit or recognition result
  typedef logic [8:0]  label_addr_t;
  typedef logic [7:0]  digit_addr_t;
  typedef logic [11:0] pix_cnt_t;     // pixels seen in a region this frame

  typedef enum logic [1:0] {
    RES_IDLE,
    RES_WAIT,
    RES_HELD
  } res_state_e;

  // region geometry, inclusive from x0/y0
  localparam int LABEL_X0 = 8;
  localparam int LABEL_Y0 = 4;
  localparam int LABEL_W  = 64;
  localparam int LABEL_H  = 8;
  localparam int MDIG_X0  = 80;
  localparam int MDIG_Y0  = 4;
  localparam int RDIG_X0  = 80;
  localparam int RDIG_Y0  = 24;
  localparam int DIG_W    = 8;
  localparam int DIG_H    = 16;

  // font roms
  localparam int LABEL_BYTES     = 64;   // one 64x8 label
  localparam int DIG_BYTES       = 16;   // one 8x16 digit
  localparam int LABEL_ROM_DEPTH = 1 << $bits(label_addr_t);
  localparam int DIG_ROM_DEPTH   = 1 << $bits(digit_addr_t);
  localparam string LABEL_FONT_FILE = "osd/label_font.mem";
  localparam string DIGIT_FONT_FILE = "osd/digit_font.mem";

  localparam pix_t   CHAR_COLOR = 24'hff_ffff;
  localparam digit_t NO_RESULT  = 3'd7;   // recognizer found nobody

  // command codes, upper nibble
  localparam logic [3:0] CMD_ECHO    = 4'h1;
  localparam logic [3:0] CMD_VCHANGE = 4'h2;
  localparam logic [3:0] CMD_NOISE   = 4'h3;
  localparam logic [3:0] CMD_SPLIT   = 4'h4;
  localparam logic [3:0] CMD_VPRINT  = 4'h5;
  // 5-bit prefixes
  localparam logic [4:0] CMD_TRAIN    = 5'b01010;   // inside vprint
  localparam logic [4:0] CMD_RECOG    = 5'b01011;   // inside vprint
  localparam logic [4:0] CMD_RECORD   = 5'b10100;
  localparam logic [4:0] CMD_PLAYBACK = 5'b10101;

  // label numbers in the label rom
  localparam logic [2:0] LBL_LOOP     = 3'd0;
  localparam logic [2:0] LBL_NOISE    = 3'd1;
  localparam logic [2:0] LBL_ECHO     = 3'd2;
  localparam logic [2:0] LBL_VCHANGE  = 3'd3;
  localparam logic [2:0] LBL_SPLIT    = 3'd4;
  localparam logic [2:0] LBL_VPRINT   = 3'd5;
  localparam logic [2:0] LBL_RECORD   = 3'd6;
  localparam logic [2:0] LBL_PLAYBACK = 3'd7;

endpackage

// File: design/status_tracker.sv
// --------------------
// command and result state
// --------------------
`timescale 1ns/1ps

module status_tracker (
  input  logic            pclk,
  input  logic            rst_n,
  input  osd_pkg::cmd_t   i_cmd,
  input  logic            i_cmd_strobe,
  input  osd_pkg::digit_t i_result,
  input  logic            i_result_strobe,
  output osd_pkg::cmd_t   o_cmd,
  output logic            o_mdig_en,
  output osd_pkg::digit_t o_mdig,
  output logic            o_rdig_en,
  output osd_pkg::digit_t o_rdig
);
  import osd_pkg::*;

  cmd_t       cmd_q;
  res_state_e res_state;
  digit_t     result_q;
  logic       new_is_recog;
  logic       is_train;
  logic       capture;

  assign new_is_recog = (i_cmd[7:3] == CMD_RECOG);
  assign is_train     = (cmd_q[7:3] == CMD_TRAIN);
  // a command strobe in the same cycle wins over the result
  assign capture      = i_result_strobe && !i_cmd_strobe && (res_state != RES_IDLE);

  always_ff @(posedge pclk or negedge rst_n) begin
    if (!rst_n) begin
      cmd_q <= '0;   // loopback
    end else if (i_cmd_strobe) begin
      cmd_q <= i_cmd;
    end
  end

  always_ff @(posedge pclk or negedge rst_n) begin
    if (!rst_n) begin
      res_state <= RES_IDLE;
    end else if (i_cmd_strobe) begin
      res_state <= new_is_recog ? RES_WAIT : RES_IDLE;   // re-arm on every recog strobe
    end else if (capture) begin
      res_state <= RES_HELD;
    end
  end

  always_ff @(posedge pclk) begin
    if (capture) begin
      result_q <= i_result;
    end
  end

  assign o_cmd     = cmd_q;
  assign o_mdig_en = (cmd_q[7:4] == CMD_NOISE) || (cmd_q[7:4] == CMD_VCHANGE) ||
                     (cmd_q[7:4] == CMD_SPLIT);
  assign o_mdig    = cmd_q[2:0];
  assign o_rdig_en = is_train || ((res_state == RES_HELD) && (result_q != NO_RESULT));
  assign o_rdig    = is_train ? cmd_q[2:0] : result_q;   // trained speaker id

endmodule

// File: design/osd_region_scan.sv
// --------------------
// osd region scanner
// --------------------
`timescale 1ns/1ps

module osd_region_scan #(
  parameter int X0 = 0,
  parameter int Y0 = 0,
  parameter int W  = 8,
  parameter int H  = 8
) (
  input  logic              pclk,
  input  logic              rst_n,
  input  osd_pkg::coord_t   i_pos_x,
  input  osd_pkg::coord_t   i_pos_y,
  input  logic              i_vs,
  output logic              o_active,
  output logic              o_active_d,
  output logic [2:0]        o_bit_idx,
  output osd_pkg::pix_cnt_t o_offset
);
  import osd_pkg::*;

  localparam coord_t X_LO = coord_t'(X0);
  localparam coord_t X_HI = coord_t'(X0 + W - 1);
  localparam coord_t Y_LO = coord_t'(Y0);
  localparam coord_t Y_HI = coord_t'(Y0 + H - 1);

  logic       hit;
  pix_cnt_t   cnt_q;
  logic [2:0] col_q;

  assign hit = (i_pos_x >= X_LO) && (i_pos_x <= X_HI) &&
               (i_pos_y >= Y_LO) && (i_pos_y <= Y_HI);

  always_ff @(posedge pclk or negedge rst_n) begin
    if (!rst_n) begin
      o_active   <= 1'b0;
      o_active_d <= 1'b0;
      col_q      <= '0;
    end else begin
      o_active   <= hit;
      o_active_d <= o_active;
      col_q      <= o_active_d ? col_q + 3'd1 : 3'd0;   // restarts each line of the region
    end
  end

  always_ff @(posedge pclk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else if (i_vs) begin
      cnt_q <= '0;
    end else if (o_active) begin
      cnt_q <= cnt_q + 12'd1;
    end
  end

  assign o_bit_idx = col_q;
  assign o_offset  = cnt_q >> 3;   // one font byte per 8 pixels

endmodule

// File: osd/mode_label_gen.sv
// --------------------
// mode label lookup
// --------------------
`timescale 1ns/1ps

module mode_label_gen (
  input  logic                  pclk,
  input  osd_pkg::cmd_t         i_cmd,
  input  osd_pkg::pix_cnt_t     i_offset,
  output osd_pkg::glyph_row_t   o_row
);
  import osd_pkg::*;

  logic [2:0]  lbl_num;
  label_addr_t addr;
  glyph_row_t  rom [LABEL_ROM_DEPTH];

  initial begin
    $readmemh(LABEL_FONT_FILE, rom);
  end

  always_comb begin
    if (i_cmd[7:3] == CMD_RECORD) begin
      lbl_num = LBL_RECORD;
    end else if (i_cmd[7:3] == CMD_PLAYBACK) begin
      lbl_num = LBL_PLAYBACK;
    end else begin
      case (i_cmd[7:4])
        CMD_ECHO:    lbl_num = LBL_ECHO;
        CMD_VCHANGE: lbl_num = LBL_VCHANGE;
        CMD_NOISE:   lbl_num = LBL_NOISE;
        CMD_SPLIT:   lbl_num = LBL_SPLIT;
        CMD_VPRINT:  lbl_num = LBL_VPRINT;   // train and recog share it
        default:     lbl_num = LBL_LOOP;
      endcase
    end
  end

  assign addr = label_addr_t'(lbl_num * LABEL_BYTES) + label_addr_t'(i_offset);

  always_ff @(posedge pclk) begin
    o_row <= rom[addr];
  end

endmodule

// File: osd/digit_font_server.sv
// --------------------
// shared digit font
// --------------------
`timescale 1ns/1ps

module digit_font_server (
  input  logic                pclk,
  input  logic                i_mreq,
  input  osd_pkg::pix_cnt_t   i_moffset,
  input  osd_pkg::digit_t     i_mdig,
  input  logic                i_rreq,
  input  osd_pkg::pix_cnt_t   i_roffset,
  input  osd_pkg::digit_t     i_rdig,
  output osd_pkg::glyph_row_t o_row
);
  import osd_pkg::*;

  logic        sel_r;
  pix_cnt_t    offset;
  digit_t      digit;
  digit_addr_t addr;
  glyph_row_t  rom [DIG_ROM_DEPTH];

  initial begin
    $readmemh(DIGIT_FONT_FILE, rom);
  end

  // mode digit has priority, regions never overlap anyway
  assign sel_r  = i_rreq && !i_mreq;
  assign offset = sel_r ? i_roffset : i_moffset;
  assign digit  = sel_r ? i_rdig : i_mdig;
  assign addr   = digit_addr_t'(digit * DIG_BYTES) + digit_addr_t'(offset);

  always_ff @(posedge pclk) begin
    o_row <= rom[addr];
  end

endmodule

// File: osd/pixel_mixer.sv
// --------------------
// overlay colour mix
// --------------------
`timescale 1ns/1ps

module pixel_mixer (
  input  logic                pclk,
  input  logic                rst_n,
  input  osd_pkg::pix_t       i_data,
  input  logic                i_lbl_act_d,
  input  logic [2:0]          i_lbl_bit,
  input  osd_pkg::glyph_row_t i_lbl_row,
  input  logic                i_mdig_act_d,
  input  logic [2:0]          i_mdig_bit,
  input  logic                i_mdig_en,
  input  logic                i_rdig_act_d,
  input  logic [2:0]          i_rdig_bit,
  input  logic                i_rdig_en,
  input  osd_pkg::glyph_row_t i_dig_row,
  output osd_pkg::pix_t       o_data
);
  import osd_pkg::*;

  pix_t data_d;
  pix_t data_dd;
  logic draw;

  // lines the video up with the rom rows
  always_ff @(posedge pclk) begin
    data_d  <= i_data;
    data_dd <= data_d;
  end

  always_comb begin
    if (i_lbl_act_d) begin
      draw = i_lbl_row[i_lbl_bit];
    end else if (i_mdig_act_d) begin
      draw = i_mdig_en && i_dig_row[i_mdig_bit];
    end else if (i_rdig_act_d) begin
      draw = i_rdig_en && i_dig_row[i_rdig_bit];
    end else begin
      draw = 1'b0;
    end
  end

  always_ff @(posedge pclk or negedge rst_n) begin
    if (!rst_n) begin
      o_data <= '0;
    end else begin
      o_data <= draw ? CHAR_COLOR : data_dd;   // glyph pixel or video
    end
  end

endmodule

// File: design/osd_overlay_top.sv
// --------------------
// osd overlay top
// --------------------
`timescale 1ns/1ps

module osd_overlay_top (
  input  logic            pclk,
  input  logic            rst_n,
  input  osd_pkg::coord_t i_pos_x,
  input  osd_pkg::coord_t i_pos_y,
  input  osd_pkg::pix_t   i_data,
  input  logic            i_vs,
  input  osd_pkg::cmd_t   i_cmd,
  input  logic            i_cmd_strobe,
  input  osd_pkg::digit_t i_result,
  input  logic            i_result_strobe,
  output osd_pkg::pix_t   o_data
);
  import osd_pkg::*;

  cmd_t       cmd;
  logic       mdig_en;
  digit_t     mdig;
  logic       rdig_en;
  digit_t     rdig;
  logic       lbl_act_d;
  logic [2:0] lbl_bit;
  pix_cnt_t   lbl_off;
  logic       mdig_act;
  logic       mdig_act_d;
  logic [2:0] mdig_bit;
  pix_cnt_t   mdig_off;
  logic       rdig_act;
  logic       rdig_act_d;
  logic [2:0] rdig_bit;
  pix_cnt_t   rdig_off;
  glyph_row_t lbl_row;
  glyph_row_t dig_row;

  status_tracker status_tracker_i (
    .pclk(pclk), .rst_n(rst_n),
    .i_cmd(i_cmd), .i_cmd_strobe(i_cmd_strobe),
    .i_result(i_result), .i_result_strobe(i_result_strobe),
    .o_cmd(cmd), .o_mdig_en(mdig_en), .o_mdig(mdig),
    .o_rdig_en(rdig_en), .o_rdig(rdig)
  );

  osd_region_scan #(.X0(LABEL_X0), .Y0(LABEL_Y0), .W(LABEL_W), .H(LABEL_H)) label_scan_i (
    .pclk(pclk), .rst_n(rst_n), .i_pos_x(i_pos_x), .i_pos_y(i_pos_y), .i_vs(i_vs),
    .o_active(), .o_active_d(lbl_act_d), .o_bit_idx(lbl_bit), .o_offset(lbl_off)
  );

  osd_region_scan #(.X0(MDIG_X0), .Y0(MDIG_Y0), .W(DIG_W), .H(DIG_H)) mdig_scan_i (
    .pclk(pclk), .rst_n(rst_n), .i_pos_x(i_pos_x), .i_pos_y(i_pos_y), .i_vs(i_vs),
    .o_active(mdig_act), .o_active_d(mdig_act_d), .o_bit_idx(mdig_bit), .o_offset(mdig_off)
  );

  osd_region_scan #(.X0(RDIG_X0), .Y0(RDIG_Y0), .W(DIG_W), .H(DIG_H)) rdig_scan_i (
    .pclk(pclk), .rst_n(rst_n), .i_pos_x(i_pos_x), .i_pos_y(i_pos_y), .i_vs(i_vs),
    .o_active(rdig_act), .o_active_d(rdig_act_d), .o_bit_idx(rdig_bit), .o_offset(rdig_off)
  );

  mode_label_gen mode_label_gen_i (
    .pclk(pclk), .i_cmd(cmd), .i_offset(lbl_off), .o_row(lbl_row)
  );

  digit_font_server digit_font_server_i (
    .pclk(pclk),
    .i_mreq(mdig_act), .i_moffset(mdig_off), .i_mdig(mdig),
    .i_rreq(rdig_act), .i_roffset(rdig_off), .i_rdig(rdig),
    .o_row(dig_row)
  );

  pixel_mixer pixel_mixer_i (
    .pclk(pclk), .rst_n(rst_n), .i_data(i_data),
    .i_lbl_act_d(lbl_act_d), .i_lbl_bit(lbl_bit), .i_lbl_row(lbl_row),
    .i_mdig_act_d(mdig_act_d), .i_mdig_bit(mdig_bit), .i_mdig_en(mdig_en),
    .i_rdig_act_d(rdig_act_d), .i_rdig_bit(rdig_bit), .i_rdig_en(rdig_en),
    .i_dig_row(dig_row), .o_data(o_data)
  );

endmodule

// File: tb/osd_overlay_asserts.sv
// --------------------
// overlay assertions
// --------------------
`timescale 1ns/1ps

module osd_overlay_asserts (
  input logic                pclk,
  input logic                rst_n,
  input osd_pkg::pix_t       i_data,
  input osd_pkg::pix_t       i_out_data,
  input logic                i_lbl_act_d,
  input logic                i_mdig_act_d,
  input logic                i_rdig_act_d,
  input osd_pkg::cmd_t       i_cmd,
  input osd_pkg::res_state_e i_res_state
);
  import osd_pkg::*;

  actives_exclusive: assert property (@(posedge pclk) disable iff (!rst_n)
    $onehot0({i_lbl_act_d, i_mdig_act_d, i_rdig_act_d}))
    else $error("more than one region active at once");

  // video path when nothing is drawn
  video_passthrough: assert property (@(posedge pclk) disable iff (!rst_n)
    ($past(rst_n, 3) && !$past(i_lbl_act_d || i_mdig_act_d || i_rdig_act_d))
    |-> (i_out_data == $past(i_data, 3)))
    else $error("video not passed through outside the regions");

  held_only_in_recog: assert property (@(posedge pclk) disable iff (!rst_n)
    (i_res_state == RES_HELD) |-> (i_cmd[7:3] == CMD_RECOG))
    else $error("result held while not in recognition");

endmodule

bind osd_overlay_top osd_overlay_asserts osd_overlay_asserts_i (
  .pclk(pclk), .rst_n(rst_n), .i_data(i_data), .i_out_data(o_data),
  .i_lbl_act_d(lbl_act_d), .i_mdig_act_d(mdig_act_d), .i_rdig_act_d(rdig_act_d),
  .i_cmd(cmd), .i_res_state(status_tracker_i.res_state)
);

// File: tb/tb_osd_overlay.sv
// --------------------
// osd overlay testbench
// --------------------
`timescale 1ns/1ps

module tb_osd_overlay;
  import osd_pkg::*;

  localparam int RASTER_W     = 96;
  localparam int RASTER_H     = 44;
  localparam int FRAMES       = 24;
  localparam int VS_CYCLES    = 4;
  localparam int FRAME_CYCLES = VS_CYCLES + RASTER_W * RASTER_H;
  localparam int CYCLE_LIMIT  = FRAMES * FRAME_CYCLES + 8 + 200;   // reset plus drain margin

  logic   pclk;
  logic   rst_n;
  coord_t i_pos_x;
  coord_t i_pos_y;
  pix_t   i_data;
  logic   i_vs;
  cmd_t   i_cmd;
  logic   i_cmd_strobe;
  digit_t i_result;
  logic   i_result_strobe;
  pix_t   o_data;

  glyph_row_t label_rom [LABEL_ROM_DEPTH];
  glyph_row_t digit_rom [DIG_ROM_DEPTH];
  logic [15:0] lfsr;
  int          errors;
  int          cycles;
  int          frame;

  // model state
  cmd_t       m_cmd;
  res_state_e m_state;
  digit_t     m_res;
  logic       draw_h [3];   // index 0 is the newest pixel
  pix_t       data_h [3];
  int         x_h [3];
  int         y_h [3];
  logic       vs_h [3];
  logic [7:0] mdig_cap [DIG_H];
  logic [7:0] rdig_cap [DIG_H];

  osd_overlay_top osd_overlay_top_i (
    .pclk(pclk), .rst_n(rst_n), .i_pos_x(i_pos_x), .i_pos_y(i_pos_y), .i_data(i_data),
    .i_vs(i_vs), .i_cmd(i_cmd), .i_cmd_strobe(i_cmd_strobe), .i_result(i_result),
    .i_result_strobe(i_result_strobe), .o_data(o_data)
  );

  initial begin
    pclk = 1'b0;
    forever #2 pclk = ~pclk;
  end

  initial begin
    cycles = 0;
    forever begin
      @(posedge pclk);
      cycles++;
      if (cycles > CYCLE_LIMIT) begin
        $display("run stopped after %0d cycles without finishing", cycles);
        $display("Errors found");
        $finish;
      end
    end
  end

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {1'b0, lfsr[15:1]} ^ (lfsr[0] ? 16'hb400 : 16'h0000);   // galois step
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic in_rect(input int x, input int y, input int x0, input int y0,
                                   input int w, input int h);
    return (x >= x0) && (x < x0 + w) && (y >= y0) && (y < y0 + h);
  endfunction

  function automatic int label_of(input cmd_t c);
    if (c[7:3] == 5'b10100) return 6;
    if (c[7:3] == 5'b10101) return 7;
    case (c[7:4])
      4'h1: return 2;   // echo
      4'h2: return 3;   // voice change
      4'h3: return 1;   // noise
      4'h4: return 4;   // split
      4'h5: return 5;   // vprint
      default: return 0;
    endcase
  endfunction

  function automatic logic mdig_on();
    return (m_cmd[7:4] == 4'h2) || (m_cmd[7:4] == 4'h3) || (m_cmd[7:4] == 4'h4);
  endfunction

  function automatic logic is_train();
    return m_cmd[7:3] == 5'b01010;
  endfunction

  function automatic logic rdig_on();
    return is_train() || ((m_state == RES_HELD) && (m_res != 3'd7));
  endfunction

  function automatic digit_t rdig_val();
    return is_train() ? m_cmd[2:0] : m_res;
  endfunction

  function automatic logic model_draw(input int x, input int y);
    int         addr;
    glyph_row_t row;
    if (in_rect(x, y, LABEL_X0, LABEL_Y0, LABEL_W, LABEL_H)) begin
      addr = label_of(m_cmd) * LABEL_BYTES + (y - LABEL_Y0) * 8 + (x - LABEL_X0) / 8;
      row  = label_rom[addr];
      return row[(x - LABEL_X0) % 8];
    end
    if (in_rect(x, y, MDIG_X0, MDIG_Y0, DIG_W, DIG_H)) begin
      row = digit_rom[int'(m_cmd[2:0]) * DIG_BYTES + y - MDIG_Y0];
      return mdig_on() && row[x - MDIG_X0];
    end
    if (in_rect(x, y, RDIG_X0, RDIG_Y0, DIG_W, DIG_H)) begin
      row = digit_rom[int'(rdig_val()) * DIG_BYTES + y - RDIG_Y0];
      return rdig_on() && row[x - RDIG_X0];
    end
    return 1'b0;
  endfunction

  task automatic check_pix(input string name, input pix_t exp, input pix_t act);
    if (act !== exp) begin
      errors++;
      $display("MISMATCH %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_cmd_digit(input string name, input digit_t exp, input digit_t act);
    if (act !== exp) begin
      errors++;
      $display("MISMATCH %s expected %0d actual %0d", name, exp, act);
    end
  endtask

  // match a captured 8x16 bitmap against the digit font
  task automatic check_region_digit(input string name, input logic en, input digit_t exp,
                                    input logic [7:0] cap [DIG_H]);
    logic   hit;
    logic   same;
    logic   blank;
    digit_t dig;
    hit   = 1'b0;
    blank = 1'b1;
    dig   = '0;
    for (int d = 0; d < 8; d++) begin
      same = 1'b1;
      for (int r = 0; r < DIG_H; r++) begin
        if (cap[r] != digit_rom[d * DIG_BYTES + r]) same = 1'b0;
      end
      if (same && !hit) begin
        hit = 1'b1;
        dig = digit_t'(d);
      end
    end
    for (int r = 0; r < DIG_H; r++) begin
      if (cap[r] != 8'h00) blank = 1'b0;
    end
    if (en && hit) begin
      check_cmd_digit(name, exp, dig);
    end else if (en) begin
      errors++;
      $display("%s shows no known digit glyph", name);
    end else if (!blank) begin
      errors++;
      $display("%s drawn although the digit is off", name);
    end
  endtask

  task automatic check_digits();
    check_region_digit($sformatf("mode digit frame %0d", frame - 1), mdig_on(),
                       m_cmd[2:0], mdig_cap);
    check_region_digit($sformatf("result digit frame %0d", frame - 1), rdig_on(),
                       rdig_val(), rdig_cap);
    for (int r = 0; r < DIG_H; r++) begin
      mdig_cap[r] = '0;
      rdig_cap[r] = '0;
    end
  endtask

  task automatic drive_cycle(input logic vs, input int x, input int y, input pix_t d,
                             input logic cstb, input cmd_t c, input logic rstb,
                             input digit_t r);
    logic  drawn;
    string name;
    @(negedge pclk);
    // o_data now answers the pixel two entries back
    drawn = (o_data == CHAR_COLOR);
    if (!vs_h[2] && in_rect(x_h[2], y_h[2], MDIG_X0, MDIG_Y0, DIG_W, DIG_H))
      mdig_cap[y_h[2] - MDIG_Y0][x_h[2] - MDIG_X0] = drawn;
    if (!vs_h[2] && in_rect(x_h[2], y_h[2], RDIG_X0, RDIG_Y0, DIG_W, DIG_H))
      rdig_cap[y_h[2] - RDIG_Y0][x_h[2] - RDIG_X0] = drawn;
    name = $sformatf("pixel frame %0d x %0d y %0d", frame, x_h[2], y_h[2]);
    check_pix(name, draw_h[2] ? CHAR_COLOR : data_h[2], o_data);
    for (int i = 2; i > 0; i--) begin
      draw_h[i] = draw_h[i - 1];
      data_h[i] = data_h[i - 1];
      x_h[i]    = x_h[i - 1];
      y_h[i]    = y_h[i - 1];
      vs_h[i]   = vs_h[i - 1];
    end
    draw_h[0] = vs ? 1'b0 : model_draw(x, y);
    data_h[0] = d;
    x_h[0]    = x;
    y_h[0]    = y;
    vs_h[0]   = vs;
    if (cstb) begin
      m_cmd   = c;
      m_state = (c[7:3] == 5'b01011) ? RES_WAIT : RES_IDLE;
    end
    if (rstb && (m_state != RES_IDLE)) begin
      m_res   = r;
      m_state = RES_HELD;
    end
    i_vs            = vs;
    i_pos_x         = coord_t'(x);
    i_pos_y         = coord_t'(y);
    i_data          = d;
    i_cmd_strobe    = cstb;
    i_cmd           = c;
    i_result_strobe = rstb;
    i_result        = r;
  endtask

  initial begin
    logic   cstb;
    logic   rstb;
    cmd_t   c;
    digit_t r;
    rst_n           = 1'b0;
    i_pos_x         = '0;
    i_pos_y         = '0;
    i_data          = '0;
    i_vs            = 1'b1;
    i_cmd           = '0;
    i_cmd_strobe    = 1'b0;
    i_result        = '0;
    i_result_strobe = 1'b0;
    lfsr            = 16'd56203;
    errors          = 0;
    frame           = 0;
    m_cmd           = '0;   // loopback after reset
    m_state         = RES_IDLE;
    m_res           = '0;
    for (int i = 0; i < 3; i++) begin
      draw_h[i] = 1'b0;
      data_h[i] = '0;
      x_h[i]    = 0;
      y_h[i]    = 0;
      vs_h[i]   = 1'b1;
    end
    for (int i = 0; i < DIG_H; i++) begin
      mdig_cap[i] = '0;
      rdig_cap[i] = '0;
    end
    $readmemh("osd/label_font.mem", label_rom);
    $readmemh("osd/digit_font.mem", digit_rom);
    repeat (8) begin
      @(negedge pclk);
      check_pix("reset output", '0, o_data);
    end
    rst_n = 1'b1;
    for (frame = 0; frame < FRAMES; frame++) begin
      if (frame > 0) check_digits();
      for (int v = 0; v < VS_CYCLES; v++) begin
        cstb = 1'b0;
        rstb = 1'b0;
        c    = '0;
        r    = '0;
        if (v == 0 && frame > 0) begin
          cstb = 1'b1;
          case (frame)
            1: c = {4'h1, 4'(rand_bits(4))};
            2: c = {4'h2, 4'(rand_bits(4))};
            3: c = {4'h3, 4'(rand_bits(4))};
            4: c = {4'h4, 4'(rand_bits(4))};
            5: c = {5'b01010, 3'(rand_bits(3))};
            6: c = {5'b01011, 3'(rand_bits(3))};
            7: c = {5'b10100, 3'(rand_bits(3))};
            8: c = {5'b10101, 3'(rand_bits(3))};
            default: begin
              cstb = (rand_bits(2) != 0);
              c    = rand_bits(1) ? {4'h5, 4'(rand_bits(4))} : cmd_t'(rand_bits(8));
            end
          endcase
        end
        if (v == 2) begin
          rstb = rand_bits(1);
          r    = digit_t'(rand_bits(3));
        end
        drive_cycle(1'b1, RASTER_W - 1, RASTER_H - 1, pix_t'(rand_bits(24)), cstb, c, rstb, r);
      end
      for (int y = 0; y < RASTER_H; y++) begin
        for (int x = 0; x < RASTER_W; x++) begin
          drive_cycle(1'b0, x, y, pix_t'(rand_bits(24)), 1'b0, '0, 1'b0, '0);
        end
      end
    end
    repeat (3) drive_cycle(1'b1, RASTER_W - 1, RASTER_H - 1, '0, 1'b0, '0, 1'b0, '0);
    check_digits();
    $display("checks done, errors: %0d", errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// File: osd/label_font.mem
// label font rom, 64 bytes per label, 4 lines per label
// each line holds 16 glyph bytes in address order, bit n at column n
00 01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0f
10 11 12 13 14 15 16 17 18 19 1a 1b 1c 1d 1e 1f
20 21 22 23 24 25 26 27 28 29 2a 2b 2c 2d 2e 2f
30 31 32 33 34 35 36 37 38 39 3a 3b 3c 3d 3e 3f
40 41 42 43 44 45 46 47 48 49 4a 4b 4c 4d 4e 4f
50 51 52 53 54 55 56 57 58 59 5a 5b 5c 5d 5e 5f
60 61 62 63 64 65 66 67 68 69 6a 6b 6c 6d 6e 6f
70 71 72 73 74 75 76 77 78 79 7a 7b 7c 7d 7e 7f
80 81 82 83 84 85 86 87 88 89 8a 8b 8c 8d 8e 8f
90 91 92 93 94 95 96 97 98 99 9a 9b 9c 9d 9e 9f
a0 a1 a2 a3 a4 a5 a6 a7 a8 a9 aa ab ac ad ae af
b0 b1 b2 b3 b4 b5 b6 b7 b8 b9 ba bb bc bd be bf
c0 c1 c2 c3 c4 c5 c6 c7 c8 c9 ca cb cc cd ce cf
d0 d1 d2 d3 d4 d5 d6 d7 d8 d9 da db dc dd de df
e0 e1 e2 e3 e4 e5 e6 e7 e8 e9 ea eb ec ed ee ef
f0 f1 f2 f3 f4 f5 f6 f7 f8 f9 fa fb fc fd fe ff
ff fe fd fc fb fa f9 f8 f7 f6 f5 f4 f3 f2 f1 f0
ef ee ed ec eb ea e9 e8 e7 e6 e5 e4 e3 e2 e1 e0
df de dd dc db da d9 d8 d7 d6 d5 d4 d3 d2 d1 d0
cf ce cd cc cb ca c9 c8 c7 c6 c5 c4 c3 c2 c1 c0
bf be bd bc bb ba b9 b8 b7 b6 b5 b4 b3 b2 b1 b0
af ae ad ac ab aa a9 a8 a7 a6 a5 a4 a3 a2 a1 a0
9f 9e 9d 9c 9b 9a 99 98 97 96 95 94 93 92 91 90
8f 8e 8d 8c 8b 8a 89 88 87 86 85 84 83 82 81 80
7f 7e 7d 7c 7b 7a 79 78 77 76 75 74 73 72 71 70
6f 6e 6d 6c 6b 6a 69 68 67 66 65 64 63 62 61 60
5f 5e 5d 5c 5b 5a 59 58 57 56 55 54 53 52 51 50
4f 4e 4d 4c 4b 4a 49 48 47 46 45 44 43 42 41 40
3f 3e 3d 3c 3b 3a 39 38 37 36 35 34 33 32 31 30
2f 2e 2d 2c 2b 2a 29 28 27 26 25 24 23 22 21 20
1f 1e 1d 1c 1b 1a 19 18 17 16 15 14 13 12 11 10
0f 0e 0d 0c 0b 0a 09 08 07 06 05 04 03 02 01 00

// File: osd/digit_font.mem
// digit font rom, one line per digit 0 to 7
// each line holds the 16 row bytes of that digit, top row first
80 81 82 83 84 85 86 87 88 89 8a 8b 8c 8d 8e 8f
90 91 92 93 94 95 96 97 98 99 9a 9b 9c 9d 9e 9f
a0 a1 a2 a3 a4 a5 a6 a7 a8 a9 aa ab ac ad ae af
b0 b1 b2 b3 b4 b5 b6 b7 b8 b9 ba bb bc bd be bf
c0 c1 c2 c3 c4 c5 c6 c7 c8 c9 ca cb cc cd ce cf
d0 d1 d2 d3 d4 d5 d6 d7 d8 d9 da db dc dd de df
e0 e1 e2 e3 e4 e5 e6 e7 e8 e9 ea eb ec ed ee ef
f0 f1 f2 f3 f4 f5 f6 f7 f8 f9 fa fb fc fd fe ff

// File: sim.f
common/osd_pkg.sv
design/status_tracker.sv
design/osd_region_scan.sv
osd/mode_label_gen.sv
osd/digit_font_server.sv
osd/pixel_mixer.sv
design/osd_overlay_top.sv
tb/osd_overlay_asserts.sv
tb/tb_osd_overlay.sv

// File: Makefile
# Verilator simulation of the osd overlay

.PHONY: help test clean

help:
	@echo "make test   build and run the testbench with Verilator"
	@echo "make clean  remove build output and log"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f sim.f \
		--top-module tb_osd_overlay -Mdir obj_dir
	./obj_dir/Vtb_osd_overlay | tee sim.log
	@grep -q "^No errors$$" sim.log

clean:
	rm -rf obj_dir sim.log
